// ==== hw/gsm_macros.svh ====
/*
 * Size constants for the grouped shared-memory switch.
 * Included by the package and by every RTL module that needs a size.
 */

`ifndef GSM_MACROS_SVH
`define GSM_MACROS_SVH

// data path
`define GSM_DWIDTH          32

// port and tile counts, fixed by the port bit-masks
`define GSM_NUM_PORTS       4
`define GSM_NUM_TILES       2
`define GSM_PORTS_PER_TILE  2

// egress queue inside a tile
`define GSM_QUEUE_DEPTH     8
`define GSM_QUEUE_AWIDTH    3

// payload beats after each header beat
`define GSM_PAYLOAD_WORDS   2

`endif

// ==== hw/gsm_pkg.sv ====
/*
 * Shared types of the switch: data word, port and tile masks,
 * and the two views of an ingress word (header or raw payload).
 */

`include "gsm_macros.svh"

package gsm_pkg;

	typedef logic [`GSM_DWIDTH-1:0] data_t;

	// one bit per egress port
	typedef logic [`GSM_NUM_PORTS-1:0] port_mask_t;

	// one-hot tile grant
	typedef logic [`GSM_NUM_TILES-1:0] tile_mask_t;

	// header view, destination mask in the low bits
	typedef struct packed {
		logic [`GSM_DWIDTH-`GSM_NUM_PORTS-1:0] reserved;
		port_mask_t                            dest_mask;
	} cell_hdr_t;

	// header beats read hdr, payload beats read raw
	typedef union packed {
		cell_hdr_t hdr;
		data_t     raw;
	} cell_word_u;

endpackage

// ==== hw/gsm_egress_queue.sv ====
/*
 * Egress queue of a tile: circular buffer with two write lanes and one
 * read port. Lane 0 is stored before lane 1; words that do not fit are lost.
 * The head word is shown combinationally and consumed by i_pop.
 */

`timescale 1ns/1ns

`include "gsm_macros.svh"

module gsm_egress_queue (
	input  logic                            clk_80M,
	input  logic                            i_rst_n,
	input  logic [`GSM_PORTS_PER_TILE-1:0]  i_wr_en,
	input  gsm_pkg::data_t                  i_wr_data [`GSM_PORTS_PER_TILE],
	input  logic                            i_pop,
	output logic                            o_valid,
	output gsm_pkg::data_t                  o_data
);

	import gsm_pkg::*;

	localparam int CNT_W = `GSM_QUEUE_AWIDTH + 1;

	data_t                       mem [`GSM_QUEUE_DEPTH];
	logic [`GSM_QUEUE_AWIDTH-1:0] rd_ptr;
	logic [`GSM_QUEUE_AWIDTH-1:0] wr_ptr;
	logic [`GSM_QUEUE_AWIDTH-1:0] wr1_addr;
	logic [CNT_W-1:0]             count;
	logic                         wr0;
	logic                         wr1;
	logic                         rd;

	// space is judged on the count before this cycle's pop
	assign wr0 = i_wr_en[0] && (count < CNT_W'(`GSM_QUEUE_DEPTH));
	assign wr1 = i_wr_en[1] && ((count + CNT_W'(wr0)) < CNT_W'(`GSM_QUEUE_DEPTH));
	assign rd  = i_pop && (count != '0);

	// lane 1 lands behind lane 0 when both write
	assign wr1_addr = wr_ptr + `GSM_QUEUE_AWIDTH'(wr0);

	always_ff @(posedge clk_80M) begin
		if (wr0) begin
			mem[wr_ptr] <= i_wr_data[0];
		end
		if (wr1) begin
			mem[wr1_addr] <= i_wr_data[1];
		end
	end

	always_ff @(posedge clk_80M) begin
		if (!i_rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + `GSM_QUEUE_AWIDTH'(wr0) + `GSM_QUEUE_AWIDTH'(wr1);
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(wr0) + CNT_W'(wr1) - CNT_W'(rd);
		end
	end

	// head of queue
	assign o_valid = (count != '0);
	assign o_data  = mem[rd_ptr];

endmodule

// ==== hw/gsm_tile.sv ====
/*
 * Shared-memory tile for two ingress ports. Each port is parsed into
 * header and payload beats; payload words are registered and then written
 * into the egress queue of every port in the latched destination mask.
 */

`timescale 1ns/1ns

`include "gsm_macros.svh"

module gsm_tile (
	input  logic                            clk_80M,
	input  logic                            i_rst_n,
	input  logic [`GSM_PORTS_PER_TILE-1:0]  i_ingress_valid,
	input  logic [`GSM_PORTS_PER_TILE-1:0]  i_ingress_header,
	input  gsm_pkg::data_t                  i_ingress_data [`GSM_PORTS_PER_TILE],
	input  gsm_pkg::port_mask_t             i_pop,
	output gsm_pkg::port_mask_t             o_q_valid,
	output gsm_pkg::data_t                  o_q_data [`GSM_NUM_PORTS]
);

	import gsm_pkg::*;

	localparam int REM_W = $clog2(`GSM_PAYLOAD_WORDS + 1);

	cell_word_u       word      [`GSM_PORTS_PER_TILE];
	port_mask_t       dest_mask [`GSM_PORTS_PER_TILE];
	logic [REM_W-1:0] remain    [`GSM_PORTS_PER_TILE];

	// registered payload beat, one lane per ingress port
	port_mask_t       lane_wr   [`GSM_PORTS_PER_TILE];
	data_t            lane_data [`GSM_PORTS_PER_TILE];

	genvar p;
	genvar e;

	generate
		for (p = 0; p < `GSM_PORTS_PER_TILE; p++) begin : g_decode
			assign word[p] = i_ingress_data[p];
		end
	endgenerate

	//************************************************************
	// ingress packet parsing
	//************************************************************
	always_ff @(posedge clk_80M) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `GSM_PORTS_PER_TILE; i++) begin
				dest_mask[i] <= '0;
				remain[i]    <= '0;
				lane_wr[i]   <= '0;
			end
		end else begin
			for (int i = 0; i < `GSM_PORTS_PER_TILE; i++) begin
				lane_wr[i] <= '0;
				if (i_ingress_valid[i] && i_ingress_header[i]) begin
					// a new header drops whatever is left of the old packet
					dest_mask[i] <= word[i].hdr.dest_mask;
					remain[i]    <= REM_W'(`GSM_PAYLOAD_WORDS);
				end else if (i_ingress_valid[i] && (remain[i] != '0)) begin
					remain[i]  <= remain[i] - 1'b1;
					lane_wr[i] <= dest_mask[i];
				end
			end
		end
	end

	always_ff @(posedge clk_80M) begin
		for (int i = 0; i < `GSM_PORTS_PER_TILE; i++) begin
			if (i_ingress_valid[i]) begin
				lane_data[i] <= word[i].raw;
			end
		end
	end

	//************************************************************
	// one queue per egress port
	//************************************************************
	generate
		for (e = 0; e < `GSM_NUM_PORTS; e++) begin : g_queue
			logic [`GSM_PORTS_PER_TILE-1:0] q_wr_en;

			for (p = 0; p < `GSM_PORTS_PER_TILE; p++) begin : g_lane
				assign q_wr_en[p] = lane_wr[p][e];
			end

			gsm_egress_queue i_gsm_egress_queue (
				.clk_80M   (clk_80M),
				.i_rst_n   (i_rst_n),
				.i_wr_en   (q_wr_en),
				.i_wr_data (lane_data),
				.i_pop     (i_pop[e]),
				.o_valid   (o_q_valid[e]),
				.o_data    (o_q_data[e])
			);
		end
	endgenerate

endmodule

// ==== hw/gsm_egress_scheduler.sv ====
/*
 * Per egress port, picks one of the two tiles by round robin, pops the
 * granted queue and registers its head word onto the egress port.
 * A stalled port issues no pop and holds its output register.
 */

`timescale 1ns/1ns

`include "gsm_macros.svh"

module gsm_egress_scheduler (
	input  logic                        clk_80M,
	input  logic                        i_rst_n,
	input  gsm_pkg::port_mask_t         i_q_valid      [`GSM_NUM_TILES],
	input  gsm_pkg::data_t              i_q_data       [`GSM_NUM_TILES][`GSM_NUM_PORTS],
	input  logic [`GSM_NUM_PORTS-1:0]   i_egress_stall,
	output gsm_pkg::port_mask_t         o_pop          [`GSM_NUM_TILES],
	output logic [`GSM_NUM_PORTS-1:0]   o_egress_valid,
	output gsm_pkg::data_t              o_egress_data  [`GSM_NUM_PORTS]
);

	import gsm_pkg::*;

	// tile granted last, per egress port
	logic [`GSM_NUM_PORTS-1:0] last_tile;
	tile_mask_t                grant [`GSM_NUM_PORTS];

	//************************************************************
	// round-robin choice
	//************************************************************
	always_comb begin
		tile_mask_t req;

		req = '0;
		for (int e = 0; e < `GSM_NUM_PORTS; e++) begin
			for (int t = 0; t < `GSM_NUM_TILES; t++) begin
				req[t] = i_q_valid[t][e];
			end

			if (i_egress_stall[e]) begin
				grant[e] = '0;
			end else if (&req) begin
				// both tiles waiting, take the one not served last
				grant[e] = last_tile[e] ? 2'b01 : 2'b10;
			end else begin
				grant[e] = req;
			end
		end
	end

	always_comb begin
		for (int t = 0; t < `GSM_NUM_TILES; t++) begin
			for (int e = 0; e < `GSM_NUM_PORTS; e++) begin
				o_pop[t][e] = grant[e][t];
			end
		end
	end

	// reset leaves tile 0 in front
	always_ff @(posedge clk_80M) begin
		if (!i_rst_n) begin
			last_tile <= '1;
		end else begin
			for (int e = 0; e < `GSM_NUM_PORTS; e++) begin
				if (|grant[e]) begin
					last_tile[e] <= grant[e][1];
				end
			end
		end
	end

	//************************************************************
	// egress output register
	//************************************************************
	always_ff @(posedge clk_80M) begin
		if (!i_rst_n) begin
			o_egress_valid <= '0;
			for (int e = 0; e < `GSM_NUM_PORTS; e++) begin
				o_egress_data[e] <= '0;
			end
		end else begin
			for (int e = 0; e < `GSM_NUM_PORTS; e++) begin
				if (!i_egress_stall[e]) begin
					o_egress_valid[e] <= |grant[e];
					case (grant[e])
						2'b01: o_egress_data[e] <= i_q_data[0][e];
						2'b10: o_egress_data[e] <= i_q_data[1][e];
						default: o_egress_data[e] <= o_egress_data[e];
					endcase
				end
			end
		end
	end

endmodule

// ==== hw/gsm_switch.sv ====
/*
 * Top level of the 4x4 grouped shared-memory switch.
 * Tile t serves ingress ports 2t and 2t+1; the egress scheduler merges
 * both tiles onto the four egress ports.
 */

`timescale 1ns/1ns

`include "gsm_macros.svh"

module gsm_switch (
	input  logic                        clk_80M,
	input  logic                        i_rst_n,

	// ingress ports
	input  logic [`GSM_NUM_PORTS-1:0]   i_ingress_valid,
	input  logic [`GSM_NUM_PORTS-1:0]   i_ingress_header,
	input  gsm_pkg::data_t              i_ingress_data [`GSM_NUM_PORTS],

	// egress ports
	input  logic [`GSM_NUM_PORTS-1:0]   i_egress_stall,
	output logic [`GSM_NUM_PORTS-1:0]   o_egress_valid,
	output gsm_pkg::data_t              o_egress_data  [`GSM_NUM_PORTS]
);

	import gsm_pkg::*;

	// tile to scheduler
	port_mask_t q_valid [`GSM_NUM_TILES];
	data_t      q_data  [`GSM_NUM_TILES][`GSM_NUM_PORTS];
	port_mask_t q_pop   [`GSM_NUM_TILES];

	genvar t;
	genvar p;

	generate
		for (t = 0; t < `GSM_NUM_TILES; t++) begin : g_tile
			data_t tile_data [`GSM_PORTS_PER_TILE];

			for (p = 0; p < `GSM_PORTS_PER_TILE; p++) begin : g_port
				assign tile_data[p] = i_ingress_data[t*`GSM_PORTS_PER_TILE + p];
			end

			gsm_tile i_gsm_tile (
				.clk_80M          (clk_80M),
				.i_rst_n          (i_rst_n),
				.i_ingress_valid  (i_ingress_valid[t*`GSM_PORTS_PER_TILE +: `GSM_PORTS_PER_TILE]),
				.i_ingress_header (i_ingress_header[t*`GSM_PORTS_PER_TILE +: `GSM_PORTS_PER_TILE]),
				.i_ingress_data   (tile_data),
				.i_pop            (q_pop[t]),
				.o_q_valid        (q_valid[t]),
				.o_q_data         (q_data[t])
			);
		end
	endgenerate

	gsm_egress_scheduler i_gsm_egress_scheduler (
		.clk_80M        (clk_80M),
		.i_rst_n        (i_rst_n),
		.i_q_valid      (q_valid),
		.i_q_data       (q_data),
		.i_egress_stall (i_egress_stall),
		.o_pop          (q_pop),
		.o_egress_valid (o_egress_valid),
		.o_egress_data  (o_egress_data)
	);

endmodule

// ==== testbench/gsm_switch_sva.sv ====
/*
 * Port-level assertions for the switch, bound into every gsm_switch.
 * Each failing assertion also bumps fail_count for the testbench to see.
 */

`timescale 1ns/1ns

`include "gsm_macros.svh"

module gsm_switch_sva (
	input  logic                        clk_80M,
	input  logic                        i_rst_n,
	input  logic [`GSM_NUM_PORTS-1:0]   i_ingress_valid,
	input  logic [`GSM_NUM_PORTS-1:0]   i_ingress_header,
	input  logic [`GSM_NUM_PORTS-1:0]   i_egress_stall,
	input  logic [`GSM_NUM_PORTS-1:0]   o_egress_valid,
	input  gsm_pkg::data_t              o_egress_data [`GSM_NUM_PORTS]
);

	import gsm_pkg::*;

	int   fail_count = 0;
	logic payload_seen;

	genvar e;

	// any non-header beat since reset
	always_ff @(posedge clk_80M) begin
		if (!i_rst_n) begin
			payload_seen <= 1'b0;
		end else if (|(i_ingress_valid & ~i_ingress_header)) begin
			payload_seen <= 1'b1;
		end
	end

	a_reset_idle: assert property (@(posedge clk_80M) !i_rst_n |=> (o_egress_valid == '0))
		else begin
			$error("egress valid is set in the cycle after reset");
			fail_count = fail_count + 1;
		end

	//************************************************************
	// per egress port
	//************************************************************
	generate
		for (e = 0; e < `GSM_NUM_PORTS; e++) begin : g_port
			a_stall_hold: assert property (@(posedge clk_80M) disable iff (!i_rst_n)
				i_egress_stall[e] |=> ($stable(o_egress_valid[e]) && $stable(o_egress_data[e])))
				else begin
					$error("egress port %0d changed while stalled", e);
					fail_count = fail_count + 1;
				end

			a_no_early_valid: assert property (@(posedge clk_80M) disable iff (!i_rst_n)
				$rose(o_egress_valid[e]) |-> payload_seen)
				else begin
					$error("egress port %0d valid rose before any payload beat", e);
					fail_count = fail_count + 1;
				end
		end
	endgenerate

endmodule

bind gsm_switch gsm_switch_sva i_gsm_switch_sva (
	.clk_80M          (clk_80M),
	.i_rst_n          (i_rst_n),
	.i_ingress_valid  (i_ingress_valid),
	.i_ingress_header (i_ingress_header),
	.i_egress_stall   (i_egress_stall),
	.o_egress_valid   (o_egress_valid),
	.o_egress_data    (o_egress_data)
);

// ==== testbench/gsm_switch_tb.sv ====
/*
 * Testbench for the 4x4 shared-memory switch. Drives packets on all
 * ingress ports, predicts each egress word per source and egress port,
 * and checks the egress streams with immediate assertions.
 */

`timescale 1ns/1ns

`include "gsm_macros.svh"

module gsm_switch_tb;

	import gsm_pkg::*;

	localparam int NP        = `GSM_NUM_PORTS;
	localparam int EXP_DEPTH = 64;
	localparam int SRC_MSB   = `GSM_DWIDTH - 1;
	localparam int RR_PORT   = 1;
	// the tests take about 400 cycles
	localparam int TIMEOUT_CYCLES = 2000;

	logic          clk_80M = 1'b0;
	logic          i_rst_n;
	logic [NP-1:0] i_ingress_valid;
	logic [NP-1:0] i_ingress_header;
	data_t         i_ingress_data [NP];
	logic [NP-1:0] i_egress_stall;
	logic [NP-1:0] o_egress_valid;
	data_t         o_egress_data  [NP];

	// beats for the next drive cycle
	logic [NP-1:0] stg_valid;
	logic [NP-1:0] stg_header;
	data_t         stg_data [NP];
	logic          stall_on = 1'b0;

	// reference packet state per ingress port
	port_mask_t ref_mask   [NP];
	int         ref_remain [NP];

	// expected words indexed by source*NP + egress
	data_t exp_mem  [NP*NP][EXP_DEPTH];
	int    exp_head [NP*NP];
	int    exp_tail [NP*NP];

	integer seed;
	int     cycle_count  = 0;
	int     seq          = 0;
	logic   payload_sent = 1'b0;
	logic   rst_done     = 1'b0;
	logic   rr_on        = 1'b0;
	int     rr_last_tile = -1;

	always #2 clk_80M = ~clk_80M;

	gsm_switch i_gsm_switch (
		.clk_80M          (clk_80M),
		.i_rst_n          (i_rst_n),
		.i_ingress_valid  (i_ingress_valid),
		.i_ingress_header (i_ingress_header),
		.i_ingress_data   (i_ingress_data),
		.i_egress_stall   (i_egress_stall),
		.o_egress_valid   (o_egress_valid),
		.o_egress_data    (o_egress_data)
	);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic push_expected(input int idx, input data_t w);
		if (exp_tail[idx] - exp_head[idx] >= EXP_DEPTH) begin
			abort_run("expected word store overflowed");
		end
		exp_mem[idx][exp_tail[idx] % EXP_DEPTH] = w;
		exp_tail[idx]++;
	endtask

	// packet rules applied to the beats being driven
	task automatic predict_beats();
		for (int p = 0; p < NP; p++) begin
			if (stg_valid[p] && stg_header[p]) begin
				ref_mask[p]   = stg_data[p][NP-1:0];
				ref_remain[p] = `GSM_PAYLOAD_WORDS;
			end else if (stg_valid[p]) begin
				payload_sent = 1'b1;
				if (ref_remain[p] > 0) begin
					for (int e = 0; e < NP; e++) begin
						if (ref_mask[p][e]) begin
							push_expected(p*NP + e, stg_data[p]);
						end
					end
					ref_remain[p]--;
				end
			end
		end
	endtask

	task automatic drive_cycle();
		@(posedge clk_80M);
		i_ingress_valid  <= stg_valid;
		i_ingress_header <= stg_header;
		for (int p = 0; p < NP; p++) begin
			i_ingress_data[p] <= stg_data[p];
		end
		i_egress_stall <= stall_on ? NP'($random(seed)) : '0;
		predict_beats();
		stg_valid  = '0;
		stg_header = '0;
	endtask

	task automatic stage_header(input int p, input port_mask_t mask);
		stg_valid[p]          = 1'b1;
		stg_header[p]         = 1'b1;
		stg_data[p]           = data_t'($random(seed));
		stg_data[p][NP-1:0]   = mask;
	endtask

	// source port, sequence number, random field
	task automatic stage_payload(input int p);
		stg_valid[p]  = 1'b1;
		stg_header[p] = 1'b0;
		stg_data[p]   = {2'(p), 10'(seq), 20'($random(seed))};
		seq++;
	endtask

	task automatic send_round(input port_mask_t ports, input logic [NP-1:0][NP-1:0] masks);
		for (int p = 0; p < NP; p++) begin
			if (ports[p]) begin
				stage_header(p, masks[p]);
			end
		end
		drive_cycle();
		for (int w = 0; w < `GSM_PAYLOAD_WORDS; w++) begin
			for (int p = 0; p < NP; p++) begin
				if (ports[p]) begin
					stage_payload(p);
				end
			end
			drive_cycle();
		end
	endtask

	function automatic logic all_drained();
		for (int i = 0; i < NP*NP; i++) begin
			if (exp_head[i] != exp_tail[i]) begin
				return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	task automatic wait_drain();
		while (!all_drained()) begin
			drive_cycle();
		end
		repeat (4) drive_cycle();
	endtask

	//************************************************************
	// egress monitor sampled between edges
	//************************************************************
	always @(negedge clk_80M) begin
		int    src;
		int    idx;
		data_t want;

		if (rst_done) begin
			assert (i_gsm_switch.i_gsm_switch_sva.fail_count == 0)
				else abort_run("a port assertion bound to the switch failed");
			assert (payload_sent || (o_egress_valid == '0))
				else abort_run($sformatf("CHECK FAILED at %0t ns: valid %b before any payload",
					$time, o_egress_valid));
			for (int e = 0; e < NP; e++) begin
				if (o_egress_valid[e] && !i_egress_stall[e]) begin
					src = o_egress_data[e][SRC_MSB -: 2];
					idx = src*NP + e;
					assert (exp_head[idx] != exp_tail[idx])
						else abort_run($sformatf("CHECK FAILED at %0t ns: unexpected word %h on port %0d",
							$time, o_egress_data[e], e));
					want = exp_mem[idx][exp_head[idx] % EXP_DEPTH];
					assert (o_egress_data[e] == want)
						else abort_run($sformatf("CHECK FAILED at %0t ns: port %0d got %h, expected %h",
							$time, e, o_egress_data[e], want));
					exp_head[idx]++;
					if (rr_on && (e == RR_PORT)) begin
						assert ((src / 2) != rr_last_tile)
							else abort_run($sformatf("CHECK FAILED at %0t ns: tile %0d served twice",
								$time, src / 2));
						rr_last_tile = src / 2;
					end
				end
			end
		end
	end

	always @(posedge clk_80M) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("timeout: the tests did not finish within the cycle limit");
		end
	end

	initial begin
		seed             = 32'h3820c7d4;
		i_rst_n          = 1'b0;
		i_ingress_valid  = '0;
		i_ingress_header = '0;
		i_egress_stall   = '0;
		stg_valid        = '0;
		stg_header       = '0;
		for (int p = 0; p < NP; p++) begin
			i_ingress_data[p] = '0;
			stg_data[p]       = '0;
			ref_mask[p]       = '0;
			ref_remain[p]     = 0;
		end
		for (int i = 0; i < NP*NP; i++) begin
			exp_head[i] = 0;
			exp_tail[i] = 0;
		end
		repeat (8) @(posedge clk_80M);
		i_rst_n <= 1'b1;
		rst_done = 1'b1;

		// idle after reset
		repeat (10) drive_cycle();

		// unicast across and within tiles
		send_round(4'b1111, {4'b0001, 4'b1000, 4'b0100, 4'b0010});
		send_round(4'b1111, {4'b1000, 4'b0100, 4'b0010, 4'b0001});
		wait_drain();

		// multicast
		send_round(4'b1001, {4'b0101, 4'b0000, 4'b0000, 4'b1111});
		send_round(4'b0110, {4'b0000, 4'b0110, 4'b1010, 4'b0000});
		wait_drain();

		// both tiles into one egress port
		rr_on = 1'b1;
		send_round(4'b0101, {4'b0000, 4'b0010, 4'b0000, 4'b0010});
		send_round(4'b0101, {4'b0000, 4'b0010, 4'b0000, 4'b0010});
		wait_drain();
		rr_on = 1'b0;

		// empty mask, stray payload, packet cut short
		send_round(4'b0010, {4'b0000, 4'b0000, 4'b0000, 4'b0000});
		stage_payload(0);
		drive_cycle();
		stage_payload(0);
		drive_cycle();
		stage_header(3, 4'b0011);
		drive_cycle();
		stage_payload(3);
		drive_cycle();
		send_round(4'b1000, {4'b1000, 4'b0000, 4'b0000, 4'b0000});
		wait_drain();

		// random masks under random stall
		stall_on = 1'b1;
		for (int r = 0; r < 10; r++) begin
			send_round(4'b1111, 16'($random(seed)));
			wait_drain();
		end
		stall_on = 1'b0;
		repeat (20) drive_cycle();

		@(negedge clk_80M);
		if (i_gsm_switch.i_gsm_switch_sva.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run("a port assertion bound to the switch failed");
		end
	end

endmodule

// ==== all.f ====
+incdir+hw
hw/gsm_pkg.sv
hw/gsm_egress_queue.sv
hw/gsm_tile.sv
hw/gsm_egress_scheduler.sv
hw/gsm_switch.sv
testbench/gsm_switch_sva.sv
testbench/gsm_switch_tb.sv
